// File: logic/cache_pkg.sv
// shared geometry, enums and structs for the two-way data cache; referenced by scoped names
package cache_pkg;

  // ----------------------------------------------------------
  // geometry
  // ----------------------------------------------------------
  localparam int ADDR_W         = 32;  // physical address
  localparam int DATA_W         = 64;  // cpu word
  localparam int STRB_W         = 8;   // bytes per word
  localparam int LINE_W         = 256; // 32-byte line
  localparam int WORDS_PER_LINE = 4;
  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 64;
  localparam int OFFSET_W       = 5;
  localparam int INDEX_W        = 6;
  localparam int TAG_W          = 21;
  localparam int WORD_SEL_W     = 2;   // offset bits 4:3

  // ----------------------------------------------------------
  // enums
  // ----------------------------------------------------------
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_LOOKUP  = 3'd1,
    ST_MISS    = 3'd2,
    ST_REPLACE = 3'd3,
    ST_REFILL  = 3'd4
  } cache_state_e;

  // ----------------------------------------------------------
  // structs
  // ----------------------------------------------------------
  // cpu request as presented with i_valid
  typedef struct packed {
    mem_op_e             op;
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic [STRB_W-1:0]   wstrb;  // active high
    logic [DATA_W-1:0]   wdata;
  } cpu_req_t;

  // write command broadcast to every way
  typedef struct packed {
    logic [INDEX_W-1:0] index;
    logic [LINE_W-1:0]  data;
    logic [LINE_W-1:0]  mask;   // bit-level write mask
    logic [TAG_W-1:0]   tag;    // new tag on fill
    logic               fill;   // load tag and valid
    logic               store;  // mark dirty
  } way_wr_t;

  // per-way lookup result
  typedef struct packed {
    logic              valid;
    logic              dirty;
    logic [TAG_W-1:0]  tag;
    logic              hit;
    logic [LINE_W-1:0] line;
  } way_rd_t;

endpackage

// File: logic/cache_way.sv
// one cache way: tag, valid, dirty and line storage with local tag compare and masked write port
`timescale 1ns/1ps

module cache_way (
  input  logic                               i_clk,
  input  logic                               i_rst,
  input  logic                               i_we,
  input  cache_pkg::way_wr_t                 i_wr,
  input  logic [cache_pkg::INDEX_W-1:0]      i_index,
  input  logic [cache_pkg::TAG_W-1:0]        i_tag,
  output cache_pkg::way_rd_t                 o_rd
);

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  logic [cache_pkg::TAG_W-1:0]  tag_q   [cache_pkg::NUM_SETS];
  logic [cache_pkg::LINE_W-1:0] line_q  [cache_pkg::NUM_SETS];
  logic [cache_pkg::NUM_SETS-1:0] valid_q;
  logic [cache_pkg::NUM_SETS-1:0] dirty_q;

  logic hit;
  logic do_write;

  assign hit = valid_q[i_index] && (tag_q[i_index] == i_tag);

  // A store without fill is a hit update. It lands only in the way that
  // holds the tag, so the controller can broadcast it to all ways.
  assign do_write = i_we && (i_wr.fill || !i_wr.store || hit);

  // ----------------------------------------------------------
  // lookup port
  // ----------------------------------------------------------
  always_comb begin
    o_rd.valid = valid_q[i_index];
    o_rd.dirty = dirty_q[i_index];
    o_rd.tag   = tag_q[i_index];
    o_rd.hit   = hit;
    o_rd.line  = line_q[i_index];
  end

  // ----------------------------------------------------------
  // write port
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (do_write) begin
      line_q[i_wr.index] <= (line_q[i_wr.index] & ~i_wr.mask) | (i_wr.data & i_wr.mask);
      if (i_wr.fill) begin
        tag_q[i_wr.index] <= i_wr.tag;  // new owner of the set
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (do_write) begin
      if (i_wr.fill) begin
        valid_q[i_wr.index] <= 1'b1;
        dirty_q[i_wr.index] <= i_wr.store;  // write-allocate leaves it dirty
      end else if (i_wr.store) begin
        dirty_q[i_wr.index] <= 1'b1;
      end
    end
  end

endmodule

// File: logic/cache_way_select.sv
// combines per-way lookup results into hit, load word and victim line for write-back
`timescale 1ns/1ps

module cache_way_select (
  input  cache_pkg::way_rd_t [cache_pkg::NUM_WAYS-1:0] i_rd,
  input  logic [cache_pkg::WORD_SEL_W-1:0]             i_word_sel,
  input  logic                                         i_victim_way,
  output logic                                         o_hit,
  output logic [cache_pkg::DATA_W-1:0]                 o_load_word,
  output logic [cache_pkg::LINE_W-1:0]                 o_victim_line,
  output logic [cache_pkg::TAG_W-1:0]                  o_victim_tag,
  output logic                                         o_victim_valid,
  output logic                                         o_victim_dirty
);

  logic [cache_pkg::NUM_WAYS-1:0] hit_vec;

  // and-or mux, hits are one-hot
  always_comb begin
    o_load_word = '0;
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      hit_vec[w] = i_rd[w].hit;
      if (i_rd[w].hit) begin
        o_load_word = o_load_word
                    | i_rd[w].line[i_word_sel*cache_pkg::DATA_W +: cache_pkg::DATA_W];
      end
    end
  end

  assign o_hit = |hit_vec;

  assign o_victim_line  = i_rd[i_victim_way].line;   // write-back payload
  assign o_victim_tag   = i_rd[i_victim_way].tag;
  assign o_victim_valid = i_rd[i_victim_way].valid;
  assign o_victim_dirty = i_rd[i_victim_way].dirty;

  // a tag lives in at most one way of a set
  always_comb begin
    if (!$isunknown(hit_vec)) begin
      assert ($onehot0(hit_vec)) else $error("more than one way hits");
    end
  end

endmodule

// File: logic/cache_ctrl.sv
// cache controller: request buffer, main FSM, replacement pointer, refill counter and way writes
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  // cpu port
  input  logic                                 i_valid,
  input  cache_pkg::cpu_req_t                  i_req,
  output logic                                 o_addr_ok,
  output logic                                 o_data_ok,
  output logic [cache_pkg::DATA_W-1:0]         o_rdata,
  // memory port
  output logic                                 o_rd_req,
  output logic [cache_pkg::ADDR_W-1:0]         o_rd_addr,
  input  logic                                 i_rd_rdy,
  input  logic                                 i_ret_valid,
  input  logic                                 i_ret_last,
  input  logic [cache_pkg::DATA_W-1:0]         i_ret_data,
  output logic                                 o_wr_req,
  output logic [cache_pkg::ADDR_W-1:0]         o_wr_addr,
  output logic [cache_pkg::LINE_W-1:0]         o_wr_data,
  input  logic                                 i_wr_rdy,
  // way side
  input  logic                                 i_hit,
  input  logic [cache_pkg::DATA_W-1:0]         i_load_word,
  input  logic [cache_pkg::LINE_W-1:0]         i_victim_line,
  input  logic [cache_pkg::TAG_W-1:0]          i_victim_tag,
  input  logic                                 i_victim_valid,
  input  logic                                 i_victim_dirty,
  output logic [cache_pkg::INDEX_W-1:0]        o_lookup_index,
  output logic [cache_pkg::TAG_W-1:0]          o_lookup_tag,
  output logic [cache_pkg::WORD_SEL_W-1:0]     o_word_sel,
  output logic                                 o_victim_way,
  output logic [cache_pkg::NUM_WAYS-1:0]       o_way_we,
  output cache_pkg::way_wr_t                   o_way_wr
);

  cache_pkg::cache_state_e              state_q;
  cache_pkg::cache_state_e              state_d;
  cache_pkg::cpu_req_t                  req_q;
  logic                                 repl_q;  // victim pointer
  logic [cache_pkg::WORD_SEL_W-1:0]     beat_q;
  logic [cache_pkg::WORD_SEL_W-1:0]     word_sel;
  logic [cache_pkg::WORD_SEL_W-1:0]     wr_sel;
  logic [cache_pkg::DATA_W-1:0]         strb_mask;
  logic [cache_pkg::DATA_W-1:0]         wr_word;
  logic [cache_pkg::DATA_W-1:0]         wr_word_mask;
  logic                                 is_store;
  logic                                 last_beat;

  assign o_addr_ok = (state_q == cache_pkg::ST_IDLE);
  assign word_sel  = req_q.offset[cache_pkg::OFFSET_W-1 -: cache_pkg::WORD_SEL_W];
  assign is_store  = (req_q.op == cache_pkg::OP_WRITE);
  assign last_beat = (state_q == cache_pkg::ST_REFILL) && i_ret_valid && i_ret_last;

  // ----------------------------------------------------------
  // request buffer and FSM
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_valid && o_addr_ok) begin
      req_q <= i_req;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::ST_IDLE:    if (i_valid) state_d = cache_pkg::ST_LOOKUP;
      cache_pkg::ST_LOOKUP:  state_d = i_hit ? cache_pkg::ST_IDLE : cache_pkg::ST_MISS;
      cache_pkg::ST_MISS:    if (i_wr_rdy) state_d = cache_pkg::ST_REPLACE;
      cache_pkg::ST_REPLACE: if (i_rd_rdy) state_d = cache_pkg::ST_REFILL;
      cache_pkg::ST_REFILL:  if (last_beat) state_d = cache_pkg::ST_IDLE;
      default:               state_d = cache_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= cache_pkg::ST_IDLE;
      repl_q  <= 1'b0;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (last_beat) begin
        repl_q <= ~repl_q;  // toggles once per miss
      end
      if (state_q == cache_pkg::ST_REPLACE) begin
        beat_q <= '0;
      end else if (state_q == cache_pkg::ST_REFILL && i_ret_valid) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // cpu and memory outputs
  // ----------------------------------------------------------
  assign o_data_ok = (state_q == cache_pkg::ST_LOOKUP && i_hit)
                   || (state_q == cache_pkg::ST_REFILL && i_ret_valid && beat_q == word_sel);
  assign o_rdata   = (state_q == cache_pkg::ST_LOOKUP) ? i_load_word : i_ret_data;

  assign o_rd_req  = (state_q == cache_pkg::ST_REPLACE);
  assign o_rd_addr = {req_q.tag, req_q.index, {cache_pkg::OFFSET_W{1'b0}}};

  // write-back leaves with the MISS->REPLACE step, only for a dirty victim
  assign o_wr_req  = (state_q == cache_pkg::ST_MISS) && i_wr_rdy
                   && i_victim_valid && i_victim_dirty;
  assign o_wr_addr = {i_victim_tag, req_q.index, {cache_pkg::OFFSET_W{1'b0}}};
  assign o_wr_data = i_victim_line;

  assign o_lookup_index = req_q.index;
  assign o_lookup_tag   = req_q.tag;
  assign o_word_sel     = word_sel;
  assign o_victim_way   = repl_q;

  // ----------------------------------------------------------
  // way write command
  // ----------------------------------------------------------
  always_comb begin
    for (int b = 0; b < cache_pkg::STRB_W; b++) begin
      strb_mask[b*8 +: 8] = {8{req_q.wstrb[b]}};
    end
  end

  always_comb begin
    o_way_we     = '0;
    wr_sel       = word_sel;
    wr_word      = req_q.wdata;
    wr_word_mask = strb_mask;
    if (state_q == cache_pkg::ST_LOOKUP) begin
      o_way_we = {cache_pkg::NUM_WAYS{i_hit && is_store}};  // hit way picks it up
    end else if (state_q == cache_pkg::ST_REFILL) begin
      o_way_we[repl_q] = i_ret_valid;
      wr_sel           = beat_q;
      wr_word_mask     = '1;
      wr_word          = i_ret_data;
      if (is_store && beat_q == word_sel) begin
        wr_word = (i_ret_data & ~strb_mask) | (req_q.wdata & strb_mask);  // store merge
      end
    end
  end

  always_comb begin
    o_way_wr.index = req_q.index;
    o_way_wr.data  = {cache_pkg::WORDS_PER_LINE{wr_word}};
    o_way_wr.mask  = '0;
    o_way_wr.mask[wr_sel*cache_pkg::DATA_W +: cache_pkg::DATA_W] = wr_word_mask;
    o_way_wr.tag   = req_q.tag;
    o_way_wr.fill  = (state_q == cache_pkg::ST_REFILL) && i_ret_last;
    o_way_wr.store = is_store && ((state_q == cache_pkg::ST_LOOKUP) || i_ret_last);
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // one o_data_ok pulse per request
  a_data_ok_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_data_ok |=> !o_data_ok);

  a_wr_req_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wr_req |=> !o_wr_req);

endmodule

// File: logic/cache_top.sv
// top level of the two-way data cache; connects controller, ways and way selector
`timescale 1ns/1ps

module cache_top (
  input  logic                           i_clk,
  input  logic                           i_rst,
  // cpu port
  input  logic                           i_valid,
  input  cache_pkg::cpu_req_t            i_req,
  output logic                           o_addr_ok,
  output logic                           o_data_ok,
  output logic [cache_pkg::DATA_W-1:0]   o_rdata,
  // memory port
  output logic                           o_rd_req,
  output logic [cache_pkg::ADDR_W-1:0]   o_rd_addr,
  input  logic                           i_rd_rdy,
  input  logic                           i_ret_valid,
  input  logic                           i_ret_last,
  input  logic [cache_pkg::DATA_W-1:0]   i_ret_data,
  output logic                           o_wr_req,
  output logic [cache_pkg::ADDR_W-1:0]   o_wr_addr,
  output logic [cache_pkg::LINE_W-1:0]   o_wr_data,
  input  logic                           i_wr_rdy
);

  // ----------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------
  cache_pkg::way_rd_t [cache_pkg::NUM_WAYS-1:0] way_rd;
  cache_pkg::way_wr_t                           way_wr;
  logic [cache_pkg::NUM_WAYS-1:0]               way_we;
  logic [cache_pkg::INDEX_W-1:0]                lookup_index;
  logic [cache_pkg::TAG_W-1:0]                  lookup_tag;
  logic [cache_pkg::WORD_SEL_W-1:0]             word_sel;
  logic                                         victim_way;
  logic                                         hit;
  logic [cache_pkg::DATA_W-1:0]                 load_word;
  logic [cache_pkg::LINE_W-1:0]                 victim_line;
  logic [cache_pkg::TAG_W-1:0]                  victim_tag;
  logic                                         victim_valid;
  logic                                         victim_dirty;

  cache_ctrl cache_ctrl_inst (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (i_valid),
    .i_req          (i_req),
    .o_addr_ok      (o_addr_ok),
    .o_data_ok      (o_data_ok),
    .o_rdata        (o_rdata),
    .o_rd_req       (o_rd_req),
    .o_rd_addr      (o_rd_addr),
    .i_rd_rdy       (i_rd_rdy),
    .i_ret_valid    (i_ret_valid),
    .i_ret_last     (i_ret_last),
    .i_ret_data     (i_ret_data),
    .o_wr_req       (o_wr_req),
    .o_wr_addr      (o_wr_addr),
    .o_wr_data      (o_wr_data),
    .i_wr_rdy       (i_wr_rdy),
    .i_hit          (hit),
    .i_load_word    (load_word),
    .i_victim_line  (victim_line),
    .i_victim_tag   (victim_tag),
    .i_victim_valid (victim_valid),
    .i_victim_dirty (victim_dirty),
    .o_lookup_index (lookup_index),
    .o_lookup_tag   (lookup_tag),
    .o_word_sel     (word_sel),
    .o_victim_way   (victim_way),
    .o_way_we       (way_we),
    .o_way_wr       (way_wr)
  );

  for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
    cache_way cache_way_inst (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_we    (way_we[w]),
      .i_wr    (way_wr),
      .i_index (lookup_index),
      .i_tag   (lookup_tag),
      .o_rd    (way_rd[w])
    );
  end

  cache_way_select cache_way_select_inst (
    .i_rd           (way_rd),
    .i_word_sel     (word_sel),
    .i_victim_way   (victim_way),
    .o_hit          (hit),
    .o_load_word    (load_word),
    .o_victim_line  (victim_line),
    .o_victim_tag   (victim_tag),
    .o_victim_valid (victim_valid),
    .o_victim_dirty (victim_dirty)
  );

endmodule

// File: dv/cache_tb.sv
// directed testbench for the data cache; drives cache_top through hits, misses and write-back
`timescale 1ns/1ps

module cache_tb;

  localparam int CLK_PERIOD      = 40;
  localparam int RST_CYCLES      = 8;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int LADDR_W         = cache_pkg::ADDR_W - cache_pkg::OFFSET_W;

  // all three lines share set 3
  localparam logic [31:0] ADDR_A = {21'h00012, 6'd3, 5'h10};  // word 2
  localparam logic [31:0] ADDR_B = {21'h00034, 6'd3, 5'h08};  // word 1
  localparam logic [31:0] ADDR_C = {21'h00056, 6'd3, 5'h18};  // word 3

  logic                                i_clk;
  logic                                i_rst;
  logic                                i_valid;
  cache_pkg::cpu_req_t                 i_req;
  logic                                o_addr_ok;
  logic                                o_data_ok;
  logic [cache_pkg::DATA_W-1:0]        o_rdata;
  logic                                o_rd_req;
  logic [cache_pkg::ADDR_W-1:0]        o_rd_addr;
  logic                                i_rd_rdy;
  logic                                i_ret_valid;
  logic                                i_ret_last;
  logic [cache_pkg::DATA_W-1:0]        i_ret_data;
  logic                                o_wr_req;
  logic [cache_pkg::ADDR_W-1:0]        o_wr_addr;
  logic [cache_pkg::LINE_W-1:0]        o_wr_data;
  logic                                i_wr_rdy;

  // memory contents and what the ports have seen
  logic [cache_pkg::LINE_W-1:0] mem_lines [logic [LADDR_W-1:0]];
  logic [31:0]                  lfsr_state;
  int                           rd_count;
  int                           wr_count;
  logic [31:0]                  rd_addr_seen;
  logic [31:0]                  wr_addr_seen;
  logic [cache_pkg::LINE_W-1:0] wr_data_seen;

  // shadow of the cache arrays
  logic [cache_pkg::LINE_W-1:0] sh_line  [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
  logic [cache_pkg::TAG_W-1:0]  sh_tag   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
  logic                         sh_valid [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
  logic                         sh_dirty [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
  logic                         sh_repl;

  cache_top cache_top_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_req       (i_req),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data),
    .o_wr_req    (o_wr_req),
    .o_wr_addr   (o_wr_addr),
    .o_wr_data   (o_wr_data),
    .i_wr_rdy    (i_wr_rdy)
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // untouched lines are made up from the LFSR, one step per bit
  function automatic logic [cache_pkg::LINE_W-1:0] mem_line(input logic [LADDR_W-1:0] laddr);
    logic [cache_pkg::LINE_W-1:0] line;
    if (!mem_lines.exists(laddr)) begin
      for (int i = 0; i < cache_pkg::LINE_W; i++) begin
        line[i]    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
      end
      mem_lines[laddr] = line;
    end
    return mem_lines[laddr];
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w, input logic [63:0] new_w,
                                              input logic [7:0] strb);
    logic [63:0] res;
    for (int b = 0; b < 8; b++) begin
      res[b*8 +: 8] = strb[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [255:0] actual,
                             input logic [255:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // ------------------------------------------------------------
  // memory responder
  // ------------------------------------------------------------
  initial begin : mem_read_port
    logic [cache_pkg::LINE_W-1:0] line;
    forever begin
      @(negedge i_clk);
      if (o_rd_req === 1'b1) begin
        rd_count++;
        rd_addr_seen = o_rd_addr;
        repeat (2) @(negedge i_clk);  // memory latency
        i_rd_rdy = 1'b1;
        @(negedge i_clk);
        i_rd_rdy = 1'b0;
        line     = mem_line(rd_addr_seen[31:5]);
        for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
          i_ret_valid = 1'b1;
          i_ret_last  = (b == cache_pkg::WORDS_PER_LINE - 1);
          i_ret_data  = line[b*64 +: 64];
          @(negedge i_clk);
        end
        i_ret_valid = 1'b0;
        i_ret_last  = 1'b0;
      end
    end
  end

  always @(negedge i_clk) begin
    if (o_wr_req === 1'b1) begin
      wr_count++;
      wr_addr_seen               = o_wr_addr;
      wr_data_seen               = o_wr_data;
      mem_lines[o_wr_addr[31:5]] = o_wr_data;  // write-back lands in memory
    end
  end

  // ------------------------------------------------------------
  // shadow model and cpu driver
  // ------------------------------------------------------------
  task automatic model_access(input logic is_write, input logic [31:0] addr,
                              input logic [7:0] strb, input logic [63:0] wdata,
                              output logic hit, output logic [63:0] word, output logic wb,
                              output logic [31:0] wb_addr, output logic [255:0] wb_line);
    int set;
    int way;
    int wsel;
    set     = addr[10:5];
    wsel    = addr[4:3];
    hit     = 1'b0;
    way     = sh_repl;
    wb      = 1'b0;
    wb_addr = '0;
    wb_line = '0;
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      if (sh_valid[set][w] && sh_tag[set][w] == addr[31:11]) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      wb                 = sh_valid[set][way] && sh_dirty[set][way];
      wb_addr            = {sh_tag[set][way], addr[10:5], 5'b0};
      wb_line            = sh_line[set][way];
      sh_line[set][way]  = mem_line(addr[31:5]);
      sh_tag[set][way]   = addr[31:11];
      sh_valid[set][way] = 1'b1;
      sh_dirty[set][way] = 1'b0;
      sh_repl            = ~sh_repl;  // pointer moves on every miss
    end
    word = sh_line[set][way][wsel*64 +: 64];
    if (is_write) begin
      sh_line[set][way][wsel*64 +: 64] = merge_bytes(word, wdata, strb);
      sh_dirty[set][way]               = 1'b1;
    end
  endtask

  task automatic cpu_access(input logic is_write, input logic [31:0] addr,
                            input logic [7:0] strb, input logic [63:0] wdata,
                            output logic [63:0] rdata, output int lat);
    @(negedge i_clk);
    i_valid      = 1'b1;
    i_req.op     = is_write ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
    i_req.tag    = addr[31:11];
    i_req.index  = addr[10:5];
    i_req.offset = addr[4:0];
    i_req.wstrb  = is_write ? strb : 8'h00;
    i_req.wdata  = wdata;
    while (!o_addr_ok) @(negedge i_clk);
    @(negedge i_clk);  // taken on the edge before
    i_valid = 1'b0;
    lat     = 0;
    do begin
      @(posedge i_clk);  // beats settled since the falling edge
      lat++;
    end while (!o_data_ok);
    rdata = o_rdata;
    @(negedge i_clk);
    while (!o_addr_ok) @(negedge i_clk);
  endtask

  task automatic run_access(input logic is_write, input logic [31:0] addr,
                            input logic [7:0] strb, input logic [63:0] wdata,
                            input logic exp_hit);
    logic [63:0]  exp_word;
    logic [63:0]  got_word;
    logic         hit;
    logic         wb;
    logic [31:0]  wb_addr;
    logic [255:0] wb_line;
    int           rd_before;
    int           wr_before;
    int           lat;
    rd_before = rd_count;
    wr_before = wr_count;
    model_access(is_write, addr, strb, wdata, hit, exp_word, wb, wb_addr, wb_line);
    cpu_access(is_write, addr, strb, wdata, got_word, lat);
    check_value("o_data_ok one cycle after accept", lat == 1, exp_hit);
    check_value("o_rd_req count", rd_count - rd_before, hit ? 0 : 1);
    check_value("o_wr_req count", wr_count - wr_before, wb ? 1 : 0);
    if (!hit) begin
      check_value("o_rd_addr", rd_addr_seen, {addr[31:5], 5'b0});
    end
    if (wb) begin
      check_value("o_wr_addr", wr_addr_seen, wb_addr);
      check_value("o_wr_data", wr_data_seen, wb_line);
    end
    if (!is_write) begin
      check_value("o_rdata", got_word, exp_word);
    end
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic test_after_reset();
    @(negedge i_clk);
    check_value("o_addr_ok", o_addr_ok, 1'b1);
    check_value("o_rd_req", o_rd_req, 1'b0);
    check_value("o_wr_req", o_wr_req, 1'b0);
    check_value("o_data_ok", o_data_ok, 1'b0);
  endtask

  task automatic test_read_miss();
    run_access(1'b0, ADDR_A, 8'h00, 64'h0, 1'b0);
  endtask

  task automatic test_read_hit();
    run_access(1'b0, ADDR_A, 8'h00, 64'h0, 1'b1);
  endtask

  task automatic test_write_hit();
    run_access(1'b1, ADDR_A, 8'h34, 64'hdead_beef_cafe_f00d, 1'b1);
    run_access(1'b0, ADDR_A, 8'h00, 64'h0, 1'b1);
  endtask

  task automatic test_write_miss();
    run_access(1'b1, ADDR_B, 8'hf0, 64'h0123_4567_89ab_cdef, 1'b0);
    run_access(1'b0, ADDR_B, 8'h00, 64'h0, 1'b1);  // merged word back
  endtask

  task automatic test_dirty_eviction();
    run_access(1'b0, ADDR_C, 8'h00, 64'h0, 1'b0);
    check_value("victim line address", wr_addr_seen, {ADDR_A[31:5], 5'b0});
    run_access(1'b0, ADDR_B, 8'h00, 64'h0, 1'b1);  // way 1 left alone
  endtask

  initial begin : watchdog
    #((RST_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
    $display("Timeout at %0t ns: the DUT never finished a request", $time);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rd_count    = 0;
    wr_count    = 0;
    lfsr_state  = 32'h1760_e50a;
    sh_repl     = 1'b0;
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_req       = '0;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    i_wr_rdy    = 1'b1;  // write side always ready
    for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
        sh_valid[s][w] = 1'b0;
        sh_dirty[s][w] = 1'b0;
      end
    end
    repeat (RST_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    test_after_reset();
    test_read_miss();
    test_read_hit();
    test_write_hit();
    test_write_miss();
    test_dirty_eviction();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: files.f
logic/cache_pkg.sv
logic/cache_way.sv
logic/cache_way_select.sv
logic/cache_ctrl.sv
logic/cache_top.sv
dv/cache_tb.sv

// File: Makefile
# Verilator build and run for the data cache testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := cache_tb
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "All tests passed!" $(LOG); then \
	  echo "simulation PASSED"; \
	else \
	  echo "simulation FAILED"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
